/* project.f */
verilog/fir_pkg.sv
verilog/sample_history.sv
verilog/systolic_preadd_section.sv
verilog/partial_sum_rounder.sv
verilog/symmetric_fir_top.sv
test/symmetric_fir_props.sv
test/symmetric_fir_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f project.f \
   --top-module symmetric_fir_tb -o symmetric_fir_sim || exit 1
out="$(./obj_dir/symmetric_fir_sim 2>&1)"
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED" && exit 0 || exit 1

/* test/symmetric_fir_props.sv */
`timescale 1ns/1ps

module symmetric_fir_props (
   input logic             clk_i,
   input logic             rst_n_i,
   input logic             in_ready_o,
   input logic             out_valid_o,
   input logic             out_ready_i,
   input fir_pkg::result_t out_data_o
);

   // a stalled result must not move
   hold_while_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
      else $error("output changed while stalled");

   // empty output, open input while in reset
   reset_state: assert property (@(posedge clk_i) !rst_n_i |-> !out_valid_o && in_ready_o)
      else $error("wrong handshake state during reset");

endmodule

/* test/symmetric_fir_tb.sv */
`timescale 1ns/1ps

module symmetric_fir_tb;

   import fir_pkg::*;

   // samples fed per test, flow control counted twice for its gaps and stalls
   // plus about ten cycles per reset for release and drain
   localparam int TOTAL_CYCLES   = 24 + 60 + 2 * 60 + 24 + 48 + 6 * 10;
   localparam int TIMEOUT_CYCLES = 2 * TOTAL_CYCLES + 200;

   logic                   clk_i = 1'b0;
   logic                   rst_n_i = 1'b1;
   logic                   in_valid_i;
   sample_t                in_data_i;
   logic                   in_ready_o;
   coeff_t [N_PAIRS-1:0]   coeffs;
   logic                   out_valid_o;
   logic                   out_ready_i;
   result_t                out_data_o;

   logic [31:0] lcg_state = 32'h4014_6a90;
   int          cycles = 0;
   int          out_count = 0;
   string       test_name = "reset";
   sample_t     samples[$];
   sample_t     stim[$];
   result_t     got[$];
   sample_t     stream_in[$];
   result_t     stream_out[$];

   symmetric_fir_top dut_i (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .in_valid_i  (in_valid_i),
      .in_data_i   (in_data_i),
      .in_ready_o  (in_ready_o),
      .coeffs_i    (coeffs),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i),
      .out_data_o  (out_data_o)
   );

   bind symmetric_fir_top symmetric_fir_props props_i (.*);

   always #10 clk_i = ~clk_i;

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic compare_result(input string name, input result_t exp, input result_t act);
      if (exp !== act) begin
         $display("ERR %s expected %0d actual %0d", name, exp, act);
         abort_run("output value mismatch");
      end
   endtask

   task automatic compare_ready(input string name, input bit exp, input bit act);
      if (exp !== act) begin
         $display("ERR %s expected in_ready %0b actual %0b", name, exp, act);
         abort_run("input ready mismatch");
      end
   endtask

   // full 16 tap reference convolution where h[15-k] mirrors h[k]
   function automatic result_t golden_output(input int m);
      longint acc;
      longint q;
      longint rem;
      int     idx;
      acc = 0;
      for (int k = 0; k < N_TAPS; k++) begin
         idx = m - k;
         if (idx >= 0) begin
            acc += longint'(samples[idx]) * longint'(coeffs[k < N_PAIRS ? k : N_TAPS - 1 - k]);
         end
      end
      // floor divide by 2^17 then round half to even
      q   = acc >>> OUT_SHIFT;
      rem = acc - (q <<< OUT_SHIFT);
      if (rem > 65536 || (rem == 65536 && q[0])) begin
         q = q + 1;
      end
      if (q > 4095) begin
         return result_t'(4095);
      end else if (q < -4096) begin
         return result_t'(-4096);
      end
      return result_t'(q);
   endfunction

   // watches both handshakes on every edge
   always @(posedge clk_i) begin
      if (rst_n_i) begin
         compare_ready(test_name, !(out_valid_o && !out_ready_i), in_ready_o);
         if (in_valid_i && in_ready_o) begin
            samples.push_back(in_data_i);
         end
         if (out_valid_o && out_ready_i) begin
            compare_result(test_name, golden_output(out_count), out_data_o);
            got.push_back(out_data_o);
            out_count++;
         end
      end
   end

   always @(posedge clk_i) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         abort_run("timeout, the tests did not finish in time");
      end
   end

   task automatic apply_reset();
      rst_n_i     = 1'b0;
      in_valid_i  = 1'b0;
      in_data_i   = '0;
      out_ready_i = 1'b1;
      repeat (3) @(posedge clk_i);
      #2;
      samples.delete();
      got.delete();
      stim.delete();
      out_count = 0;
      rst_n_i = 1'b1;
   endtask

   // pushes stim into the filter with random gaps and stalls if asked
   task automatic feed_samples(input bit gaps);
      int          idx;
      logic [31:0] r;
      idx = 0;
      @(posedge clk_i);
      #2;
      while (idx < stim.size()) begin
         r           = next_random();
         in_valid_i  = gaps ? (r[20] | r[21]) : 1'b1;
         out_ready_i = gaps ? (r[24] | r[25]) : 1'b1;
         in_data_i   = stim[idx];
         #1;
         if (in_valid_i && in_ready_o) begin
            idx++;
         end
         @(posedge clk_i);
         #2;
      end
      in_valid_i  = 1'b0;
      out_ready_i = 1'b1;
   endtask

   // each accepted sample past the fill depth gives one result
   task automatic wait_outputs();
      int n;
      n = stim.size() - FILL_DEPTH;
      while (out_count < n) begin
         @(posedge clk_i);
      end
      repeat (3) @(posedge clk_i);
      #2;
      if (out_count != n) begin
         abort_run($sformatf("%s gave %0d outputs instead of %0d", test_name, out_count, n));
      end
   endtask

   task automatic impulse_test();
      test_name = "impulse";
      apply_reset();
      // 1024 * 128 = 2^17 so the unit response lands on integers
      for (int k = 0; k < N_PAIRS; k++) begin
         coeffs[k] = coeff_t'((k + 1) * 128);
      end
      stim.push_back(sample_t'(1024));
      repeat (23) stim.push_back('0);
      feed_samples(1'b0);
      wait_outputs();
      for (int m = 0; m < N_TAPS; m++) begin
         compare_result(test_name, result_t'(m < N_PAIRS ? m + 1 : N_TAPS - m), got[m]);
      end
   endtask

   task automatic random_stream_test();
      logic [31:0] r;
      test_name = "random_stream";
      apply_reset();
      for (int k = 0; k < N_PAIRS; k++) begin
         r = next_random();
         coeffs[k] = coeff_t'(r[29:12]);
      end
      stream_in.delete();
      for (int i = 0; i < 60; i++) begin
         r = next_random();
         stim.push_back(sample_t'(r[27:16]));
         stream_in.push_back(sample_t'(r[27:16]));
      end
      feed_samples(1'b0);
      wait_outputs();
      // model outputs for these samples, expected again under flow control
      stream_out.delete();
      for (int m = 0; m < stream_in.size() - FILL_DEPTH; m++) begin
         stream_out.push_back(golden_output(m));
      end
   endtask

   task automatic rounding_tie_test();
      sample_t ins[8];
      result_t exp[8];
      test_name = "rounding_ties";
      apply_reset();
      // half weight on the outer pair makes every odd sample an exact tie
      coeffs = '0;
      coeffs[0] = coeff_t'(65536);
      ins = '{1, 3, -1, -3, 5, -5, 2, 7};
      exp = '{0, 2, 0, -2, 2, -2, 1, 4};
      foreach (ins[i]) stim.push_back(ins[i]);
      repeat (16) stim.push_back('0);
      feed_samples(1'b0);
      wait_outputs();
      for (int m = 0; m < 8; m++) begin
         compare_result(test_name, exp[m], got[m]);
      end
   endtask

   task automatic saturation_test();
      test_name = "saturation";
      apply_reset();
      for (int k = 0; k < N_PAIRS; k++) begin
         coeffs[k] = coeff_t'(131071);
      end
      repeat (16) stim.push_back(sample_t'(2047));
      repeat (16) stim.push_back(sample_t'(-2048));
      repeat (16) stim.push_back('0);
      feed_samples(1'b0);
      wait_outputs();
      // full windows of each sign
      compare_result(test_name, RESULT_MAX, got[15]);
      compare_result(test_name, RESULT_MIN, got[31]);
   endtask

   task automatic flow_control_test();
      test_name = "flow_control";
      apply_reset();
      stim = stream_in;
      feed_samples(1'b1);
      wait_outputs();
      for (int m = 0; m < stream_out.size(); m++) begin
         compare_result(test_name, stream_out[m], got[m]);
      end
   endtask

   initial begin
      coeffs = '0;
      apply_reset();
      impulse_test();
      random_stream_test();
      flow_control_test();
      rounding_tie_test();
      saturation_test();
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

/* verilog/fir_pkg.sv */
package fir_pkg;

   // data widths
   localparam int SAMPLE_W = 12;
   localparam int COEFF_W  = 18;
   // one guard bit so the preadder never wraps
   localparam int PREADD_W = SAMPLE_W + 1;
   localparam int PROD_W   = PREADD_W + COEFF_W;
   localparam int ACC_W    = 48;
   // output keeps the NBITS+1 convention
   localparam int RESULT_W = SAMPLE_W + 1;

   typedef logic signed [SAMPLE_W-1:0] sample_t;
   typedef logic signed [PREADD_W-1:0] preadd_t;
   typedef logic signed [COEFF_W-1:0]  coeff_t;
   typedef logic signed [PROD_W-1:0]   prod_t;
   typedef logic signed [ACC_W-1:0]    acc_t;
   typedef logic signed [RESULT_W-1:0] result_t;

   // filter geometry
   localparam int N_TAPS         = 16;
   localparam int N_PAIRS        = N_TAPS / 2;
   localparam int N_SECTION_TAPS = 4;

   // coefficients carry 17 fractional bits
   localparam int OUT_SHIFT = 17;
   localparam int TRUNC_W   = ACC_W - OUT_SHIFT;
   typedef logic signed [TRUNC_W-1:0] trunc_t;

   localparam result_t RESULT_MAX = result_t'(4095);
   localparam result_t RESULT_MIN = result_t'(-4096);

   // near input reg, preadd, product, then four cascade sum regs
   localparam int SECTION_LATENCY = 2 * N_SECTION_TAPS - 1;
   // one more step for the rounder output register
   localparam int FILL_DEPTH      = SECTION_LATENCY + 1;
   localparam int FILL_CNT_W      = $clog2(FILL_DEPTH + 1);
   typedef logic [FILL_CNT_W-1:0] fill_cnt_t;

endpackage

/* verilog/partial_sum_rounder.sv */
`timescale 1ns/1ps

module partial_sum_rounder (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              step_i,
   input  fir_pkg::acc_t     sum_a_i,
   input  fir_pkg::acc_t     sum_b_i,
   output logic              out_valid_o,
   input  logic              out_ready_i,
   output fir_pkg::result_t  out_data_o
);

   import fir_pkg::*;

   acc_t      total;
   trunc_t    trunc;
   trunc_t    rounded;
   logic      round_up;
   result_t   sat;
   fill_cnt_t fill_cnt_q;
   logic      filled;

   assign total = sum_a_i + sum_b_i;
   assign trunc = total[ACC_W-1:OUT_SHIFT];

   // convergent rounding
   // up when above half, on an exact half only if the kept lsb is odd
   assign round_up = total[OUT_SHIFT-1] & ((|total[OUT_SHIFT-2:0]) | trunc[0]);
   assign rounded  = trunc + trunc_t'(round_up);

   // clip to the 13 bit output range
   always_comb begin
      if (rounded > RESULT_MAX) begin
         sat = RESULT_MAX;
      end else if (rounded < RESULT_MIN) begin
         sat = RESULT_MIN;
      end else begin
         sat = result_t'(rounded);
      end
   end

   // counts accepted samples until the pipeline holds real data
   assign filled = (fill_cnt_q == fill_cnt_t'(FILL_DEPTH));

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         fill_cnt_q  <= '0;
         out_valid_o <= 1'b0;
      end else if (step_i) begin
         if (!filled) begin
            fill_cnt_q <= fill_cnt_q + 1'b1;
         end
         out_valid_o <= filled;
      end else if (out_ready_i) begin
         // result taken and nothing new behind it
         out_valid_o <= 1'b0;
      end
   end

   // a step only happens once the old result is gone
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         out_data_o <= '0;
      end else if (step_i) begin
         out_data_o <= sat;
      end
   end

endmodule

/* verilog/sample_history.sv */
`timescale 1ns/1ps

module sample_history (
   input  logic             clk_i,
   input  logic             rst_n_i,
   input  logic             step_i,
   input  fir_pkg::sample_t sample_i,
   output fir_pkg::sample_t near_a_o,
   output fir_pkg::sample_t far_a_o,
   output fir_pkg::sample_t near_b_o,
   output fir_pkg::sample_t far_b_o
);

   import fir_pkg::*;

   // hist_q[k] holds x[n-k] after the step that accepted x[n]
   sample_t hist_q [N_TAPS];

   // shift only on an accepted sample
   // everything starts at zero so early outputs see an empty line
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < N_TAPS; i++) begin
            hist_q[i] <= '0;
         end
      end else if (step_i) begin
         hist_q[0] <= sample_i;
         for (int i = 1; i < N_TAPS; i++) begin
            hist_q[i] <= hist_q[i-1];
         end
      end
   end

   // section A works on pairs 0..3
   // newest sample against the oldest one
   assign near_a_o = hist_q[0];
   assign far_a_o  = hist_q[N_TAPS-1];

   // section B works on pairs 4..7
   // same structure, both streams moved one section inwards
   assign near_b_o = hist_q[N_SECTION_TAPS];
   assign far_b_o  = hist_q[N_TAPS-1-N_SECTION_TAPS];

endmodule

/* verilog/symmetric_fir_top.sv */
`timescale 1ns/1ps

module symmetric_fir_top (
   input  logic                                   clk_i,
   input  logic                                   rst_n_i,
   input  logic                                   in_valid_i,
   input  fir_pkg::sample_t                       in_data_i,
   output logic                                   in_ready_o,
   input  fir_pkg::coeff_t [fir_pkg::N_PAIRS-1:0] coeffs_i,
   output logic                                   out_valid_o,
   input  logic                                   out_ready_i,
   output fir_pkg::result_t                       out_data_o
);

   import fir_pkg::*;

   logic    step;
   sample_t near_a;
   sample_t far_a;
   sample_t near_b;
   sample_t far_b;
   acc_t    sum_a;
   acc_t    sum_b;

   // accept when the output slot is free or being emptied this cycle
   assign in_ready_o = !out_valid_o || out_ready_i;
   // every datapath register advances only on this strobe
   assign step       = in_valid_i && in_ready_o;

   sample_history hist_i (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .step_i   (step),
      .sample_i (in_data_i),
      .near_a_o (near_a),
      .far_a_o  (far_a),
      .near_b_o (near_b),
      .far_b_o  (far_b)
   );

   // pairs 0..3 take h0..h3
   systolic_preadd_section sec_a_i (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .step_i   (step),
      .near_i   (near_a),
      .far_i    (far_a),
      .coeff0_i (coeffs_i[0]),
      .coeff1_i (coeffs_i[1]),
      .coeff2_i (coeffs_i[2]),
      .coeff3_i (coeffs_i[3]),
      .sum_o    (sum_a)
   );

   // pairs 4..7 take h4..h7
   systolic_preadd_section sec_b_i (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .step_i   (step),
      .near_i   (near_b),
      .far_i    (far_b),
      .coeff0_i (coeffs_i[N_SECTION_TAPS]),
      .coeff1_i (coeffs_i[N_SECTION_TAPS+1]),
      .coeff2_i (coeffs_i[N_SECTION_TAPS+2]),
      .coeff3_i (coeffs_i[N_SECTION_TAPS+3]),
      .sum_o    (sum_b)
   );

   partial_sum_rounder rnd_i (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .step_i      (step),
      .sum_a_i     (sum_a),
      .sum_b_i     (sum_b),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i),
      .out_data_o  (out_data_o)
   );

endmodule

/* verilog/systolic_preadd_section.sv */
`timescale 1ns/1ps

module systolic_preadd_section (
   input  logic             clk_i,
   input  logic             rst_n_i,
   input  logic             step_i,
   input  fir_pkg::sample_t near_i,
   input  fir_pkg::sample_t far_i,
   input  fir_pkg::coeff_t  coeff0_i,
   input  fir_pkg::coeff_t  coeff1_i,
   input  fir_pkg::coeff_t  coeff2_i,
   input  fir_pkg::coeff_t  coeff3_i,
   output fir_pkg::acc_t    sum_o
);

   import fir_pkg::*;

   // near stream walks two registers per tap so that tap k sees a sample
   // k older than tap 0 once the cascade skew of k steps is included
   localparam int NEAR_DEPTH = 2 * N_SECTION_TAPS - 1;

   //   near -> |Z| -- |Z| --> next tap
   //            |
   //   far --> |Z|-(+)-|Z| -(x)- |Z|
   //                              |
   //   sum in --------------- (+)-|Z|--> sum out

   sample_t near_q [NEAR_DEPTH];
   sample_t far_q  [N_SECTION_TAPS];
   preadd_t pre_q  [N_SECTION_TAPS];
   prod_t   prod_q [N_SECTION_TAPS];
   acc_t    sum_q  [N_SECTION_TAPS];
   coeff_t  coeff  [N_SECTION_TAPS];

   assign coeff[0] = coeff0_i;
   assign coeff[1] = coeff1_i;
   assign coeff[2] = coeff2_i;
   assign coeff[3] = coeff3_i;

   // sample delay lines
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int j = 0; j < NEAR_DEPTH; j++) begin
            near_q[j] <= '0;
         end
         for (int k = 0; k < N_SECTION_TAPS; k++) begin
            far_q[k] <= '0;
         end
      end else if (step_i) begin
         near_q[0] <= near_i;
         for (int j = 1; j < NEAR_DEPTH; j++) begin
            near_q[j] <= near_q[j-1];
         end
         // far sample is broadcast, every tap keeps its own input register
         // (same job as the D register of a DSP slice)
         for (int k = 0; k < N_SECTION_TAPS; k++) begin
            far_q[k] <= far_i;
         end
      end
   end

   // preadd, multiply and the systolic sum cascade
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int k = 0; k < N_SECTION_TAPS; k++) begin
            pre_q[k]  <= '0;
            prod_q[k] <= '0;
            sum_q[k]  <= '0;
         end
      end else if (step_i) begin
         for (int k = 0; k < N_SECTION_TAPS; k++) begin
            // 13 bit result, sign extension comes from the signed types
            pre_q[k]  <= near_q[2*k] + far_q[k];
            prod_q[k] <= pre_q[k] * coeff[k];
         end
         // first tap starts the chain
         sum_q[0] <= prod_q[0];
         for (int k = 1; k < N_SECTION_TAPS; k++) begin
            sum_q[k] <= sum_q[k-1] + prod_q[k];
         end
      end
   end

   // last cascade register is the partial sum
   assign sum_o = sum_q[N_SECTION_TAPS-1];

endmodule
